// File: compile.f
+incdir+.
fss_pkg.sv
fss_lfsr.sv
fss_stream_table.sv
fss_choose_stream.sv
fss_top.sv
fss_chk.sv
fss_tb.sv

// File: Bender.yml
package:
  name: fss

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fss_pkg.sv
      - fss_lfsr.sv
      - fss_stream_table.sv
      - fss_choose_stream.sv
      - fss_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fss_chk.sv
      - fss_tb.sv

// File: fss_tb.sv
// Testbench with clock, reset, table reference model, directed and random stimulus and report
`timescale 1ns/1ns
`include "fss_consts.svh"

module fss_tb;
	import fss_pkg::*;

	// Reset, six directed tests, random phase, idle cycles and a margin
	localparam int CYCLE_LIMIT = 8 + 20 + 60 + 100 + 100 + 210 + 300 + 10 + 200;

	logic                                       clk = 1'b0;
	logic                                       rst;
	logic                                       cmd_valid;
	stream_cmd_t                                cmd;
	logic [`FSS_THREADS-1:0][`FSS_PROB_WID-1:0] thread_prob;
	logic                                       is_buffered;
	logic                                       fetch_adv;
	stream_id_t                                 act_stream;
	stream_state_t                              state;
	logic                                       fork_done;
	stream_id_t                                 fork_stream;
	logic                                       cmd_err;

	// Reference copy of the stream table
	logic [`FSS_STREAMS-1:0]  ref_live;
	xidx_t [`FSS_THREADS-1:0] ref_prim;

	int seed = 32'h176b367d;
	int cycles = 0;
	int errors = 0;
	int test_errors = 0;
	int asrt_seen = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int alt_hits = 0;
	int n;

	fss_top u_dut (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles because the tests did not finish", cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	task automatic begin_test();
		test_errors = 0;
		alt_hits = 0;
		asrt_seen = u_dut.u_chk.fail_count;
	endtask

	// One idle cycle lets the assertions see the last change of the test
	task automatic finish_test(input string name);
		fetch_adv = 1'b0;
		next_cycle();
		test_errors += u_dut.u_chk.fail_count - asrt_seen;
		errors += test_errors;
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %s done, %0d errors, %0d advances on alternates",
			name, test_errors, alt_hits);
	endtask

	// Expected next stream is the highest live stream that wins a primary or
	// an alternate draw, and with no winner fetch stays on the current stream
	function automatic stream_id_t expect_next(input logic [`FSS_PROB_WID-1:0] rnd);
		stream_id_t pick;
		int         t;
		logic       prim_hit;
		logic       alt_hit;
		pick = '0;
		for (int s = 0; s < `FSS_STREAMS; s++) begin
			t = s / `FSS_XSTREAMS;
			prim_hit = int'(ref_prim[t]) == s % `FSS_XSTREAMS && rnd < thread_prob[t];
			alt_hit = is_buffered && rnd < (thread_prob[t] >> 3);
			if (ref_live[s] && (prim_hit || alt_hit))
				pick = stream_id_t'(s);
		end
		if (pick != '0)
			return pick;
		return act_stream;
	endfunction

	task automatic run_cycles(input int count, input bit rand_inputs);
		stream_id_t exp;
		thread_id_t thr;
		repeat (count) begin
			if (rand_inputs) begin
				fetch_adv = $random(seed);
				is_buffered = $random(seed);
				// Roughly one thread in four is switched off
				for (int t = 0; t < `FSS_THREADS; t++)
					thread_prob[t] = ($random(seed) % 4 == 0) ? '0 : $random(seed);
			end
			exp = fetch_adv ? expect_next(u_dut.lfsr_out[`FSS_PROB_WID-1:0]) : act_stream;
			next_cycle();
			check_val("act_stream", exp, act_stream);
			thr = act_stream[`FSS_SID_WID-1 -: `FSS_TID_WID];
			if (act_stream[`FSS_XID_WID-1:0] != ref_prim[thr])
				alt_hits++;
		end
	endtask

	// Applies the table rules to the reference, issues the command and compares
	task automatic send_cmd(input stream_op_t op, input int thr, input int tgt);
		logic       exp_done;
		logic       exp_err;
		stream_id_t exp_fork;
		int         t;
		int         sid;
		exp_done = 1'b0;
		exp_err = 1'b0;
		exp_fork = '0;
		t = tgt / `FSS_XSTREAMS;
		case (op)
			STRM_FORK: begin
				// Lowest free stream of the thread, never stream 0
				for (int i = 0; i < `FSS_XSTREAMS; i++) begin
					sid = thr * `FSS_XSTREAMS + i;
					if (!exp_done && sid != 0 && !ref_live[sid]) begin
						exp_done = 1'b1;
						exp_fork = stream_id_t'(sid);
					end
				end
				exp_err = !exp_done;
				if (exp_done)
					ref_live[exp_fork] = 1'b1;
			end
			STRM_KILL: begin
				exp_err = !ref_live[tgt] || int'(ref_prim[t]) == tgt % `FSS_XSTREAMS;
				if (!exp_err)
					ref_live[tgt] = 1'b0;
			end
			STRM_PROMOTE: begin
				exp_err = !ref_live[tgt];
				if (!exp_err) begin
					ref_live[t * `FSS_XSTREAMS + int'(ref_prim[t])] = 1'b0;
					ref_live[tgt] = 1'b1;
					ref_prim[t] = xidx_t'(tgt % `FSS_XSTREAMS);
				end
			end
			default: ;
		endcase
		cmd_valid = 1'b1;
		fetch_adv = 1'b0;
		cmd.op = op;
		cmd.thread = thread_id_t'(thr);
		cmd.target = stream_id_t'(tgt);
		next_cycle();
		cmd_valid = 1'b0;
		check_val("fork_done", exp_done, fork_done);
		check_val("cmd_err", exp_err, cmd_err);
		if (exp_done)
			check_val("fork_stream", exp_fork, fork_stream);
		check_val("state.live", ref_live, state.live);
		check_val("state.primary", ref_prim, state.primary);
	endtask

	initial begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		thread_prob = '0;
		is_buffered = 1'b0;
		fetch_adv = 1'b0;
		// Streams 1, 4, 8 and 12 live, thread 0 on index 1 and the rest on index 0
		ref_live = 16'h1112;
		ref_prim = 8'b00_00_00_01;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// ====================
		// Directed tests
		// ====================

		begin_test();
		check_val("act_stream", 1, act_stream);
		check_val("state.live", ref_live, state.live);
		check_val("state.primary", ref_prim, state.primary);
		check_val("fork_done", 0, fork_done);
		check_val("cmd_err", 0, cmd_err);
		finish_test("reset");

		// Thread 2 gives 9, 10 and 11, then it is full
		begin_test();
		repeat (4) send_cmd(STRM_FORK, 2, 0);
		send_cmd(STRM_KILL, 0, 8);
		send_cmd(STRM_KILL, 0, 10);
		send_cmd(STRM_PROMOTE, 0, 9);
		// Old primary 8 is free now, a kill fails and the next fork takes it back
		send_cmd(STRM_KILL, 0, 8);
		send_cmd(STRM_FORK, 2, 0);
		send_cmd(STRM_FORK, 0, 0);
		send_cmd(STRM_PROMOTE, 0, 5);
		send_cmd(STRM_NOP, 0, 0);
		finish_test("table");

		begin_test();
		thread_prob = {8'd200, 8'd100, 8'd50, 8'd150};
		is_buffered = 1'b1;
		run_cycles(30, 0);
		thread_prob = '0;
		fetch_adv = 1'b1;
		run_cycles(30, 0);
		finish_test("hold");

		// Thread 2 is switched off
		begin_test();
		thread_prob = {8'd200, 8'd0, 8'd90, 8'd160};
		fetch_adv = 1'b1;
		run_cycles(100, 0);
		finish_test("live_enabled");

		begin_test();
		thread_prob = {8'd60, 8'd120, 8'd40, 8'd255};
		is_buffered = 1'b0;
		fetch_adv = 1'b1;
		run_cycles(100, 0);
		finish_test("unbuffered");

		// Only thread 1 is on, so any advance with a byte below its alternate
		// share lands on its highest live stream, which is an alternate
		begin_test();
		repeat (3) send_cmd(STRM_FORK, 1, 0);
		thread_prob = '0;
		thread_prob[1] = 8'd255;
		is_buffered = 1'b1;
		fetch_adv = 1'b1;
		run_cycles(200, 0);
		if (alt_hits == 0) begin
			$display("At %0t ns act_stream reached no alternate stream in 200 advances",
				$time);
			test_errors++;
		end
		finish_test("buffered");

		// ====================
		// Random phase
		// ====================

		begin_test();
		for (n = 0; n < 300; n++) begin
			if (($random(seed) & 7) == 0)
				send_cmd(stream_op_t'($random(seed) & 3), $random(seed) & 3, $random(seed) & 15);
			else
				run_cycles(1, 1);
		end
		finish_test("random");

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: fss_chk.sv
// Concurrent assertions on stream choice and table sanity, bound into the top level
`timescale 1ns/1ns
`include "fss_consts.svh"

module fss_chk (
	input logic                                       clk,
	input logic                                       rst,
	input logic                                       fetch_adv,
	input logic                                       is_buffered,
	input logic [`FSS_THREADS-1:0][`FSS_PROB_WID-1:0] thread_prob,
	input fss_pkg::stream_state_t                     state,
	input fss_pkg::stream_id_t                        act_stream
);
	import fss_pkg::*;

	// Failures seen so far, read back by the testbench after every test
	int fail_count = 0;

	// Chooser inputs of the cycle that produced the current act_stream
	logic [`FSS_STREAMS-1:0]                    prev_live;
	xidx_t [`FSS_THREADS-1:0]                   prev_prim;
	logic [`FSS_THREADS-1:0][`FSS_PROB_WID-1:0] prev_prob;
	logic                                       prev_buffered;

	// Thread and in-thread index of the active stream
	thread_id_t act_thread;
	xidx_t      act_idx;

	assign act_thread = act_stream[`FSS_SID_WID-1 -: `FSS_TID_WID];
	assign act_idx = act_stream[`FSS_XID_WID-1:0];

	always_ff @(posedge clk) begin
		prev_live <= state.live;
		prev_prim <= state.primary;
		prev_prob <= thread_prob;
		prev_buffered <= is_buffered;
	end

	function automatic void count_failure(input string what);
		fail_count++;
		$error("%s", what);
	endfunction

	// ====================
	// Chooser
	// ====================

	// act_stream only moves on an advance
	a_hold: assert property (@(posedge clk) disable iff (rst)
		!fetch_adv |=> $stable(act_stream))
		else count_failure("act_stream changed without fetch_adv");

	// All threads off means no candidate ever, so fetch stays put
	a_all_off: assert property (@(posedge clk) disable iff (rst)
		fetch_adv && (thread_prob == '0) |=> $stable(act_stream))
		else count_failure("act_stream changed with every probability at zero");

	// A new stream must have been live, in a thread with nonzero probability
	a_live_enabled: assert property (@(posedge clk) disable iff (rst)
		$changed(act_stream) |-> prev_live[act_stream] && (prev_prob[act_thread] != '0))
		else count_failure("act_stream moved to a dead stream or a disabled thread");

	// Fetch from the cache never picks an alternate path
	a_unbuf_primary: assert property (@(posedge clk) disable iff (rst)
		$changed(act_stream) && !prev_buffered |-> prev_prim[act_thread] == act_idx)
		else count_failure("act_stream moved to an alternate while unbuffered");

	// ====================
	// Stream table
	// ====================

	// Stream 0 stands for no stream and is never live
	a_no_stream0: assert property (@(posedge clk) disable iff (rst)
		!state.live[0])
		else count_failure("stream 0 became live");

endmodule

bind fss_top fss_chk u_chk (.*);

// File: fss_top.sv
// Top level of the fetch stream scheduler joining LFSR, stream table and chooser
`timescale 1ns/1ns
`include "fss_consts.svh"

module fss_top (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       cmd_valid,
	input  fss_pkg::stream_cmd_t                       cmd,
	input  logic [`FSS_THREADS-1:0][`FSS_PROB_WID-1:0] thread_prob,
	input  logic                                       is_buffered,
	input  logic                                       fetch_adv,
	output fss_pkg::stream_id_t                        act_stream,
	output fss_pkg::stream_state_t                     state,
	output logic                                       fork_done,
	output fss_pkg::stream_id_t                        fork_stream,
	output logic                                       cmd_err
);

	// Random word, only the low byte feeds the chooser
	logic [`FSS_LFSR_WID-1:0] lfsr_out;

	// ====================
	// Random source
	// ====================

	fss_lfsr u_lfsr (
		.clk      (clk),
		.rst      (rst),
		.lfsr_out (lfsr_out)
	);

	// ====================
	// Stream table
	// ====================

	// Table state goes straight out as well as into the chooser
	fss_stream_table u_table (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.state       (state),
		.fork_done   (fork_done),
		.fork_stream (fork_stream),
		.cmd_err     (cmd_err)
	);

	// ====================
	// Chooser
	// ====================

	fss_choose_stream u_choose (
		.clk         (clk),
		.rst         (rst),
		.thread_prob (thread_prob),
		.is_buffered (is_buffered),
		.state       (state),
		.rnd         (lfsr_out[`FSS_PROB_WID-1:0]),
		.fetch_adv   (fetch_adv),
		.act_stream  (act_stream)
	);

endmodule

// File: fss_choose_stream.sv
// Probability-weighted choice of the next fetch stream and the active stream register
`timescale 1ns/1ns
`include "fss_consts.svh"

module fss_choose_stream (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic [`FSS_THREADS-1:0][`FSS_PROB_WID-1:0] thread_prob,
	input  logic                                       is_buffered,
	input  fss_pkg::stream_state_t                     state,
	input  logic [`FSS_PROB_WID-1:0]                   rnd,
	input  logic                                       fetch_adv,
	output fss_pkg::stream_id_t                        act_stream
);
	import fss_pkg::*;

	// Highest stream that won its draw, zero when nobody won
	stream_id_t cand;

	// Stream that fetch moves to on the next advance
	stream_id_t next_act_stream;

	// ====================
	// Stream scan
	// ====================

	// Every stream draws against its thread's probability using the same
	// random byte, so streams of one thread win or lose together
	// A probability of zero can never beat the random byte, which disables
	// the thread entirely
	// The scan runs upwards and each winner replaces the one before, so the
	// highest-numbered winner is what is left at the end
	always_comb begin : scan
		thread_id_t               thrd;
		xidx_t                    idx;
		logic [`FSS_PROB_WID-1:0] alt_prob;
		cand = '0;
		for (int n = 0; n < `FSS_STREAMS; n++) begin
			thrd = thread_id_t'(n >> `FSS_XID_WID);
			idx = xidx_t'(n);
			// Alternates get one eighth of the thread's share
			alt_prob = thread_prob[thrd] >> 3;

			// Alternate paths only draw when the fetch comes from a buffer
			// rather than the cache
			if (is_buffered && state.live[n] && (rnd < alt_prob)) begin
				cand = stream_id_t'(n);
			end

			// The thread's primary path draws at the full probability
			if (state.live[n] && (state.primary[thrd] == idx) &&
				(rnd < thread_prob[thrd])) begin
				cand = stream_id_t'(n);
			end
		end
	end

	// ====================
	// Active stream
	// ====================

	// Nothing chosen means fetch stays where it is
	assign next_act_stream = (cand != '0) ? cand : act_stream;

	// Loads only on an advance, otherwise the fetch unit keeps its stream
	// Out of reset fetch starts on thread 0's primary, stream 1
	always_ff @(posedge clk) begin
		if (rst) begin
			act_stream <= stream_id_t'(1);
		end else if (fetch_adv) begin
			act_stream <= next_act_stream;
		end
	end

endmodule

// File: fss_stream_table.sv
// Live stream bitmap and per-thread primary stream with fork, kill and promote
`timescale 1ns/1ns
`include "fss_consts.svh"

module fss_stream_table (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  fss_pkg::stream_cmd_t   cmd,
	output fss_pkg::stream_state_t state,
	output logic                   fork_done,
	output fss_pkg::stream_id_t    fork_stream,
	output logic                   cmd_err
);
	import fss_pkg::*;

	// Next value of the table and of the result strobes
	stream_state_t state_d;
	logic          fork_done_d;
	logic          cmd_err_d;

	// Result of the free stream search for the fork thread
	logic          free_found;
	xidx_t         free_idx;
	stream_id_t    fork_sid;

	// Decoded target of a kill or promote
	thread_id_t    tgt_thread;
	xidx_t         tgt_idx;
	logic          tgt_live;
	logic          tgt_primary;
	stream_id_t    old_primary_sid;

	// Reset picture: index 0 is primary in every thread except thread 0,
	// which uses index 1 since stream 0 stands for no stream
	function automatic stream_state_t reset_state();
		stream_state_t s;
		s.live = '0;
		for (int t = 0; t < `FSS_THREADS; t++) begin
			s.primary[t] = (t == 0) ? xidx_t'(1) : xidx_t'(0);
			s.live[t * `FSS_XSTREAMS + int'(s.primary[t])] = 1'b1;
		end
		return s;
	endfunction

	// ====================
	// Target decode
	// ====================

	// The target id carries its own thread in the upper bits
	assign tgt_thread = cmd.target[`FSS_SID_WID-1 -: `FSS_TID_WID];
	assign tgt_idx = cmd.target[`FSS_XID_WID-1:0];
	assign tgt_live = state.live[cmd.target];
	assign tgt_primary = (state.primary[tgt_thread] == tgt_idx);

	// Stream that loses primary status on a promote
	assign old_primary_sid = {tgt_thread, state.primary[tgt_thread]};

	// ====================
	// Free stream search
	// ====================

	// Priority search over the fork thread from the top index down, so the
	// lowest free index is the one left standing
	always_comb begin : free_search
		stream_id_t sid;
		free_found = 1'b0;
		free_idx = '0;
		for (int i = `FSS_XSTREAMS - 1; i >= 0; i--) begin
			sid = stream_id_t'(int'(cmd.thread) * `FSS_XSTREAMS + i);
			// Stream 0 is never handed out
			if (sid != '0 && !state.live[sid]) begin
				free_found = 1'b1;
				free_idx = xidx_t'(i);
			end
		end
	end

	assign fork_sid = {cmd.thread, free_idx};

	// ====================
	// Command apply
	// ====================

	always_comb begin
		state_d = state;
		fork_done_d = 1'b0;
		cmd_err_d = 1'b0;
		if (cmd_valid) begin
			case (cmd.op)
				STRM_FORK: begin
					// A full thread cannot take another path
					if (free_found) begin
						state_d.live[fork_sid] = 1'b1;
						fork_done_d = 1'b1;
					end else begin
						cmd_err_d = 1'b1;
					end
				end
				STRM_KILL: begin
					// Only a live alternate may be freed
					if (tgt_live && !tgt_primary) begin
						state_d.live[cmd.target] = 1'b0;
					end else begin
						cmd_err_d = 1'b1;
					end
				end
				STRM_PROMOTE: begin
					// Old primary is cleared first so promoting the current
					// primary leaves the table as it was
					if (tgt_live) begin
						state_d.live[old_primary_sid] = 1'b0;
						state_d.live[cmd.target] = 1'b1;
						state_d.primary[tgt_thread] = tgt_idx;
					end else begin
						cmd_err_d = 1'b1;
					end
				end
				default: begin
					// NOP leaves everything alone
				end
			endcase
		end
	end

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= reset_state();
			fork_done <= 1'b0;
			cmd_err <= 1'b0;
		end else begin
			state <= state_d;
			fork_done <= fork_done_d;
			cmd_err <= cmd_err_d;
		end
	end

	// Id of the new stream, valid alongside fork_done
	always_ff @(posedge clk) begin
		if (fork_done_d) begin
			fork_stream <= fork_sid;
		end
	end

endmodule

// File: fss_lfsr.sv
// Free-running 27-bit maximal-length Fibonacci LFSR
`timescale 1ns/1ns
`include "fss_consts.svh"

module fss_lfsr (
	input  logic                     clk,
	input  logic                     rst,
	output logic [`FSS_LFSR_WID-1:0] lfsr_out
);

	// Any nonzero value works as a seed since the all-zero state is the only
	// one outside the maximal cycle
	localparam logic [`FSS_LFSR_WID-1:0] SEED = 27'h2d593a7;

	logic feedback;

	// ====================
	// Feedback
	// ====================

	// Taps 27, 5, 2 and 1 give the polynomial x^27 + x^5 + x^2 + x + 1,
	// which steps through all 2^27 - 1 nonzero states
	assign feedback = lfsr_out[`FSS_LFSR_WID-1] ^ lfsr_out[4] ^
		lfsr_out[1] ^ lfsr_out[0];

	// ====================
	// Shift register
	// ====================

	// Shift left one place per clock with the new bit entering at the bottom
	// There is no enable, the generator runs continuously after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_out <= SEED;
		end else begin
			lfsr_out <= {lfsr_out[`FSS_LFSR_WID-2:0], feedback};
		end
	end

	// The low byte changes every cycle, which is what the chooser
	// compares against the thread probabilities

endmodule

// File: fss_pkg.sv
// Stream, thread and command types plus the stream table state struct
`include "fss_consts.svh"

package fss_pkg;

	// ====================
	// Identifiers
	// ====================

	// Full stream number, thread in the upper bits and in-thread index below
	// Value zero is reserved to mean no stream at all
	typedef logic [`FSS_SID_WID-1:0] stream_id_t;

	// Hardware thread number
	typedef logic [`FSS_TID_WID-1:0] thread_id_t;

	// Index of a stream inside its own thread
	typedef logic [`FSS_XID_WID-1:0] xidx_t;

	// ====================
	// Commands
	// ====================

	// Opcodes the branch logic sends to the stream table
	typedef enum logic [1:0] {
		STRM_NOP     = 2'd0,
		STRM_FORK    = 2'd1,
		STRM_KILL    = 2'd2,
		STRM_PROMOTE = 2'd3
	} stream_op_t;

	// Fork uses the thread field, kill and promote use the target stream id
	typedef struct packed {
		stream_op_t op;
		thread_id_t thread;
		stream_id_t target;
	} stream_cmd_t;

	// Live bitmap over all streams and the primary index of every thread
	typedef struct packed {
		logic [`FSS_STREAMS-1:0]     live;
		xidx_t [`FSS_THREADS-1:0]    primary;
	} stream_state_t;

endpackage

// File: fss_consts.svh
// Project-wide size macros for the fetch stream scheduler
`ifndef FSS_CONSTS_SVH
`define FSS_CONSTS_SVH

// ====================
// Base sizes
// ====================

// Number of hardware threads sharing the fetch unit
`define FSS_THREADS 4
// Fetch streams owned by each thread, one primary and the rest alternates
`define FSS_XSTREAMS 4
// Width of the pseudo-random generator
`define FSS_LFSR_WID 27
// Width of the per-thread fetch probability
`define FSS_PROB_WID 8

// ====================
// Derived sizes
// ====================

// Total stream count across all threads
`define FSS_STREAMS (`FSS_THREADS * `FSS_XSTREAMS)
// Bits for a thread number, a stream index within a thread, and a full stream id
`define FSS_TID_WID $clog2(`FSS_THREADS)
`define FSS_XID_WID $clog2(`FSS_XSTREAMS)
`define FSS_SID_WID (`FSS_TID_WID + `FSS_XID_WID)

`endif
